// ==== Bender.yml ====
package:
  name: periph_system

sources:
  - design/bus_pkg.sv
  - design/soc_map_pkg.sv
  - design/l1_arbiter.sv
  - design/l1_bus.sv
  - design/data_ram.sv
  - design/gpio.sv
  - design/timer.sv
  - design/periph_system.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_periph_system.sv

// ==== design/bus_pkg.sv ====
package bus_pkg;

  // data path
  localparam int DataWidth = 32;
  localparam int BeWidth   = DataWidth / 8;

  // addressing
  localparam int AddrWidth    = 32;
  localparam int DevAddrWidth = 20;  // offset inside a device region

  // hosts on the shared bus
  localparam int NumHosts = 2;

  // host index, also the bit/slot position in the packed host ports
  typedef enum logic [0:0] {
    host_core  = 1'b0,  // core data port
    host_accel = 1'b1   // accelerator host port
  } host_e;

endpackage

// ==== design/data_ram.sv ====
`timescale 1ns/1ps

module data_ram import bus_pkg::*; #(
  parameter int RamWords = 16384
) (
  input  logic                    clk_sys_in,
  input  logic                    rst_sys_in,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [BeWidth-1:0]      be_i,
  input  logic [DevAddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]    wdata_i,
  output logic [DataWidth-1:0]    rdata_o
);

  localparam int IdxWidth = (RamWords > 1) ? $clog2(RamWords) : 1;

  logic [DataWidth-1:0] mem [RamWords];
  logic [IdxWidth-1:0]  word_idx;

  assign word_idx = addr_i[IdxWidth+1:2];  // byte offset to word, wraps if smaller

  always_ff @(posedge clk_sys_in) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (be_i[b]) begin
            mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[word_idx];  // read data one cycle later
      end
    end
  end

  // full write then read of the same word returns the written data
  a_write_read: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    (req_i && we_i && be_i == '1) ##1 (req_i && !we_i && addr_i == $past(addr_i))
    |=> (rdata_o == $past(wdata_i, 2)));

endmodule

// ==== design/gpio.sv ====
`timescale 1ns/1ps

module gpio import bus_pkg::*, soc_map_pkg::*; #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 8
) (
  input  logic                    clk_sys_in,
  input  logic                    rst_sys_in,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [BeWidth-1:0]      be_i,
  input  logic [DevAddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]    wdata_i,
  output logic [DataWidth-1:0]    rdata_o,
  input  logic [GpiWidth-1:0]     gp_i,
  output logic [GpoWidth-1:0]     gp_o
);

  logic [GpiWidth-1:0] gp_meta_q;  // first sync stage
  logic [GpiWidth-1:0] gp_in_q;    // gpio_in register
  logic [GpoWidth-1:0] gp_out_q;
  gpio_reg_e           reg_sel;

  assign reg_sel = gpio_reg_e'(addr_i[RegOffWidth-1:0]);
  assign gp_o    = gp_out_q;

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      gp_meta_q <= '0;
      gp_in_q   <= '0;
      gp_out_q  <= '0;
    end else begin
      gp_meta_q <= gp_i;
      gp_in_q   <= gp_meta_q;
      if (req_i && we_i && reg_sel == gpio_out) begin
        for (int i = 0; i < GpoWidth; i++) begin
          if (be_i[i/8]) begin
            gp_out_q[i] <= wdata_i[i];
          end
        end
      end
    end
  end

  // gpio_in ignores writes, unknown offsets read zero
  always_ff @(posedge clk_sys_in) begin
    if (req_i && !we_i) begin
      case (reg_sel)
        gpio_out: rdata_o <= DataWidth'(gp_out_q);
        gpio_in:  rdata_o <= DataWidth'(gp_in_q);
        default:  rdata_o <= '0;
      endcase
    end
  end

endmodule

// ==== design/l1_arbiter.sv ====
`timescale 1ns/1ps

module l1_arbiter import bus_pkg::*; (
  input  logic                clk_sys_in,
  input  logic                rst_sys_in,
  input  logic [NumHosts-1:0] req_i,
  output logic [NumHosts-1:0] gnt_o
);

  host_e last_q;  // host granted most recently

  always_comb begin
    gnt_o = '0;
    if (req_i[host_core] && req_i[host_accel]) begin
      // tie goes to the host that lost last time
      if (last_q == host_core) begin
        gnt_o[host_accel] = 1'b1;
      end else begin
        gnt_o[host_core] = 1'b1;
      end
    end else begin
      gnt_o = req_i;  // zero or one requester
    end
  end

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      last_q <= host_accel;  // core wins the first tie
    end else if (gnt_o[host_core]) begin
      last_q <= host_core;
    end else if (gnt_o[host_accel]) begin
      last_q <= host_accel;
    end
  end

  for (genvar h = 0; h < NumHosts; h++) begin : g_chk
    a_gnt_has_req: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
      gnt_o[h] |-> req_i[h]);
  end

endmodule

// ==== design/l1_bus.sv ====
`timescale 1ns/1ps

module l1_bus import bus_pkg::*, soc_map_pkg::*; #(
  parameter int RamWords = 16384
) (
  input  logic                                clk_sys_in,
  input  logic                                rst_sys_in,

  // host side
  input  logic [NumHosts-1:0]                 host_req_i,
  input  logic [NumHosts-1:0][AddrWidth-1:0]  host_addr_i,
  input  logic [NumHosts-1:0]                 host_we_i,
  input  logic [NumHosts-1:0][BeWidth-1:0]    host_be_i,
  input  logic [NumHosts-1:0][DataWidth-1:0]  host_wdata_i,
  output logic [NumHosts-1:0]                 host_gnt_o,
  output logic [NumHosts-1:0]                 host_rvalid_o,
  output logic [NumHosts-1:0][DataWidth-1:0]  host_rdata_o,
  output logic [NumHosts-1:0]                 host_err_o,

  // device side
  output logic                                ram_req_o,
  output logic                                gpio_req_o,
  output logic                                timer_req_o,
  output logic [DevAddrWidth-1:0]             dev_addr_o,
  output logic                                dev_we_o,
  output logic [BeWidth-1:0]                  dev_be_o,
  output logic [DataWidth-1:0]                dev_wdata_o,
  input  logic [DataWidth-1:0]                ram_rdata_i,
  input  logic [DataWidth-1:0]                gpio_rdata_i,
  input  logic [DataWidth-1:0]                timer_rdata_i
);

  logic [NumHosts-1:0]  gnt;
  logic                 any_gnt;
  host_e                sel_host;
  logic [AddrWidth-1:0] sel_addr;
  logic [AddrWidth-1:0] region_base;
  logic [AddrWidth-1:0] offset;
  device_e              sel_dev;

  // transaction in flight, answered next cycle
  logic                 rsp_valid_q;
  host_e                rsp_host_q;
  device_e              rsp_dev_q;
  logic                 rsp_we_q;
  logic [DataWidth-1:0] rsp_rdata;

  l1_arbiter u_arbiter (
    .clk_sys_in,
    .rst_sys_in,
    .req_i(host_req_i),
    .gnt_o(gnt)
  );

  ////////////////////////////////////////
  // request side

  assign host_gnt_o = gnt;
  assign any_gnt    = |gnt;
  assign sel_host   = gnt[host_accel] ? host_accel : host_core;
  assign sel_addr   = host_addr_i[sel_host];

  always_comb begin
    sel_dev     = dev_none;
    region_base = '0;
    if (sel_addr >= RamStart && sel_addr < RamStart + RamSize) begin
      sel_dev     = dev_ram;
      region_base = RamStart;
    end else if (sel_addr >= GpioStart && sel_addr < GpioStart + GpioSize) begin
      sel_dev     = dev_gpio;
      region_base = GpioStart;
    end else if (sel_addr >= TimerStart && sel_addr < TimerStart + TimerSize) begin
      sel_dev     = dev_timer;
      region_base = TimerStart;
    end
  end

  assign offset      = sel_addr - region_base;  // strip the region base
  assign dev_addr_o  = offset[DevAddrWidth-1:0];
  assign dev_we_o    = host_we_i[sel_host];
  assign dev_be_o    = host_be_i[sel_host];
  assign dev_wdata_o = host_wdata_i[sel_host];

  // no strobe for dev_none
  assign ram_req_o   = any_gnt && (sel_dev == dev_ram);
  assign gpio_req_o  = any_gnt && (sel_dev == dev_gpio);
  assign timer_req_o = any_gnt && (sel_dev == dev_timer);

  ////////////////////////////////////////
  // response side

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      rsp_valid_q <= 1'b0;
      rsp_host_q  <= host_core;
      rsp_dev_q   <= dev_none;
      rsp_we_q    <= 1'b0;
    end else begin
      rsp_valid_q <= any_gnt;
      if (any_gnt) begin
        rsp_host_q <= sel_host;
        rsp_dev_q  <= sel_dev;
        rsp_we_q   <= dev_we_o;
      end
    end
  end

  always_comb begin
    rsp_rdata = '0;  // writes and errors return zero
    if (!rsp_we_q) begin
      case (rsp_dev_q)
        dev_ram:   rsp_rdata = ram_rdata_i;
        dev_gpio:  rsp_rdata = gpio_rdata_i;
        dev_timer: rsp_rdata = timer_rdata_i;
        default:   rsp_rdata = '0;
      endcase
    end
  end

  // only the granted host sees the response
  always_comb begin
    host_rvalid_o = '0;
    host_rdata_o  = '0;
    host_err_o    = '0;
    if (rsp_valid_q) begin
      host_rvalid_o[rsp_host_q] = 1'b1;
      host_rdata_o[rsp_host_q]  = rsp_rdata;
      host_err_o[rsp_host_q]    = (rsp_dev_q == dev_none);
    end
  end

  a_dev_onehot: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    $onehot0({ram_req_o, gpio_req_o, timer_req_o}));

  // response lands on the port granted one cycle before
  a_rvalid_after_gnt: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    (host_rvalid_o != '0) |-> (host_rvalid_o == $past(host_gnt_o)));

  a_ram_in_range: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    ram_req_o |-> (dev_addr_o[DevAddrWidth-1:2] < RamWords));

endmodule

// ==== design/periph_system.sv ====
`timescale 1ns/1ps

module periph_system import bus_pkg::*; #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 8,
  parameter int RamWords = 16384
) (
  input  logic                                clk_sys_in,
  input  logic                                rst_sys_in,

  // host side
  input  logic [NumHosts-1:0]                 host_req_i,
  input  logic [NumHosts-1:0][AddrWidth-1:0]  host_addr_i,
  input  logic [NumHosts-1:0]                 host_we_i,
  input  logic [NumHosts-1:0][BeWidth-1:0]    host_be_i,
  input  logic [NumHosts-1:0][DataWidth-1:0]  host_wdata_i,
  output logic [NumHosts-1:0]                 host_gnt_o,
  output logic [NumHosts-1:0]                 host_rvalid_o,
  output logic [NumHosts-1:0][DataWidth-1:0]  host_rdata_o,
  output logic [NumHosts-1:0]                 host_err_o,

  // pins
  input  logic [GpiWidth-1:0]                 gp_i,
  output logic [GpoWidth-1:0]                 gp_o,
  output logic                                timer_irq_o
);

  // device request strobes
  logic                    ram_req;
  logic                    gpio_req;
  logic                    timer_req;

  // shared request fields
  logic [DevAddrWidth-1:0] dev_addr;
  logic                    dev_we;
  logic [BeWidth-1:0]      dev_be;
  logic [DataWidth-1:0]    dev_wdata;

  // read data back to the bus
  logic [DataWidth-1:0]    ram_rdata;
  logic [DataWidth-1:0]    gpio_rdata;
  logic [DataWidth-1:0]    timer_rdata;

  ////////////////////////////////////////
  // interconnect

  l1_bus #(
    .RamWords(RamWords)
  ) u_l1_bus (
    .clk_sys_in,
    .rst_sys_in,
    .host_req_i,
    .host_addr_i,
    .host_we_i,
    .host_be_i,
    .host_wdata_i,
    .host_gnt_o,
    .host_rvalid_o,
    .host_rdata_o,
    .host_err_o,
    .ram_req_o    (ram_req),
    .gpio_req_o   (gpio_req),
    .timer_req_o  (timer_req),
    .dev_addr_o   (dev_addr),
    .dev_we_o     (dev_we),
    .dev_be_o     (dev_be),
    .dev_wdata_o  (dev_wdata),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .timer_rdata_i(timer_rdata)
  );

  ////////////////////////////////////////
  // devices

  data_ram #(
    .RamWords(RamWords)
  ) u_data_ram (
    .clk_sys_in,
    .rst_sys_in,
    .req_i  (ram_req),
    .we_i   (dev_we),
    .be_i   (dev_be),
    .addr_i (dev_addr),
    .wdata_i(dev_wdata),
    .rdata_o(ram_rdata)
  );

  gpio #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_in,
    .rst_sys_in,
    .req_i  (gpio_req),
    .we_i   (dev_we),
    .be_i   (dev_be),
    .addr_i (dev_addr),
    .wdata_i(dev_wdata),
    .rdata_o(gpio_rdata),
    .gp_i,
    .gp_o
  );

  timer u_timer (
    .clk_sys_in,
    .rst_sys_in,
    .req_i      (timer_req),
    .we_i       (dev_we),
    .be_i       (dev_be),
    .addr_i     (dev_addr),
    .wdata_i    (dev_wdata),
    .rdata_o    (timer_rdata),
    .timer_irq_o
  );

endmodule

// ==== design/soc_map_pkg.sv ====
package soc_map_pkg;

  ////////////////////////////////////////
  // address map

  localparam logic [31:0] RamStart   = 32'h0020_0000;
  localparam logic [31:0] RamSize    = 32'h0001_0000;  // 64 KiB
  localparam logic [31:0] GpioStart  = 32'h8000_0000;
  localparam logic [31:0] GpioSize   = 32'h0000_1000;  // 4 KiB
  localparam logic [31:0] TimerStart = 32'h8000_2000;
  localparam logic [31:0] TimerSize  = 32'h0000_1000;  // 4 KiB

  // register offset bits inside a 4 KiB region
  localparam int RegOffWidth = 12;

  // decoded target of a bus request
  typedef enum logic [1:0] {
    dev_ram,
    dev_gpio,
    dev_timer,
    dev_none  // unmapped, answered with err
  } device_e;

  ////////////////////////////////////////
  // register offsets

  typedef enum logic [RegOffWidth-1:0] {
    gpio_out = 12'h000,
    gpio_in  = 12'h004
  } gpio_reg_e;

  typedef enum logic [RegOffWidth-1:0] {
    tmr_mtime_lo = 12'h000,
    tmr_mtime_hi = 12'h004,
    tmr_cmp_lo   = 12'h008,
    tmr_cmp_hi   = 12'h00C
  } timer_reg_e;

endpackage

// ==== design/timer.sv ====
`timescale 1ns/1ps

module timer import bus_pkg::*, soc_map_pkg::*; (
  input  logic                    clk_sys_in,
  input  logic                    rst_sys_in,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [BeWidth-1:0]      be_i,
  input  logic [DevAddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]    wdata_i,
  output logic [DataWidth-1:0]    rdata_o,
  output logic                    timer_irq_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] cmp_q;
  logic [63:0] cmp_d;
  logic        irq_q;
  logic        wr;
  timer_reg_e  reg_sel;

  // replace the byte lanes selected by be
  function automatic logic [DataWidth-1:0] merge_be(
    input logic [DataWidth-1:0] old_val,
    input logic [DataWidth-1:0] wdata,
    input logic [BeWidth-1:0]   be
  );
    logic [DataWidth-1:0] res;
    res = old_val;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign reg_sel = timer_reg_e'(addr_i[RegOffWidth-1:0]);
  assign wr      = req_i && we_i;

  ////////////////////////////////////////
  // counter and compare

  always_comb begin
    mtime_d = mtime_q + 64'd1;  // free running
    cmp_d   = cmp_q;
    if (wr) begin
      case (reg_sel)
        tmr_mtime_lo: mtime_d[31:0]  = merge_be(mtime_q[31:0], wdata_i, be_i);
        tmr_mtime_hi: mtime_d[63:32] = merge_be(mtime_q[63:32], wdata_i, be_i);
        tmr_cmp_lo:   cmp_d[31:0]    = merge_be(cmp_q[31:0], wdata_i, be_i);
        tmr_cmp_hi:   cmp_d[63:32]   = merge_be(cmp_q[63:32], wdata_i, be_i);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      mtime_q <= '0;
      cmp_q   <= '1;  // keeps the irq low out of reset
      irq_q   <= 1'b0;
    end else begin
      mtime_q <= mtime_d;
      cmp_q   <= cmp_d;
      irq_q   <= (mtime_q >= cmp_q);  // level, one cycle behind
    end
  end

  assign timer_irq_o = irq_q;

  ////////////////////////////////////////
  // register read

  always_ff @(posedge clk_sys_in) begin
    if (req_i && !we_i) begin
      case (reg_sel)
        tmr_mtime_lo: rdata_o <= mtime_q[31:0];
        tmr_mtime_hi: rdata_o <= mtime_q[63:32];
        tmr_cmp_lo:   rdata_o <= cmp_q[31:0];
        tmr_cmp_hi:   rdata_o <= cmp_q[63:32];
        default:      rdata_o <= '0;
      endcase
    end
  end

endmodule

// ==== sim.f ====
+incdir+verification
design/bus_pkg.sv
design/soc_map_pkg.sv
design/l1_arbiter.sv
design/l1_bus.sv
design/data_ram.sv
design/gpio.sv
design/timer.sv
design/periph_system.sv
verification/tb_periph_system.sv

// ==== verification/periph_model.svh ====
`ifndef PERIPH_MODEL_SVH
`define PERIPH_MODEL_SVH

  ////////////////////////////////////////
  // model state

  logic [DataWidth-1:0] ram_model [RamWords];
  logic [GpoWidth-1:0]  gpo_model  = '0;
  logic [63:0]          cmp_model  = '1;  // mtimecmp out of reset
  host_e                last_model = host_accel;  // core wins the first tie

  // region test as [start, start+size)
  function automatic device_e decode_addr(input logic [AddrWidth-1:0] addr);
    if ((addr - RamStart) < RamSize) begin
      return dev_ram;
    end
    if ((addr - GpioStart) < GpioSize) begin
      return dev_gpio;
    end
    if ((addr - TimerStart) < TimerSize) begin
      return dev_timer;
    end
    return dev_none;
  endfunction

  // host that should win, given the request levels
  function automatic host_e expected_winner(input logic [NumHosts-1:0] req);
    if (req[host_core] && req[host_accel]) begin
      return (last_model == host_core) ? host_accel : host_core;
    end
    return req[host_accel] ? host_accel : host_core;
  endfunction

  // apply one granted access, return what the response should carry
  function automatic void model_apply(
    input  logic [AddrWidth-1:0] addr,
    input  logic                 we,
    input  logic [BeWidth-1:0]   be,
    input  logic [DataWidth-1:0] wdata,
    output logic [DataWidth-1:0] exp_rdata,
    output logic                 exp_err,
    output logic                 known
  );
    logic [AddrWidth-1:0] off;
    int                   idx;
    exp_rdata = '0;
    exp_err   = 1'b0;
    known     = 1'b1;
    case (decode_addr(addr))
      dev_ram: begin
        off = addr - RamStart;
        idx = (off >> 2) % RamWords;
        for (int b = 0; b < BeWidth; b++) begin
          if (we && be[b]) begin
            ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        if (!we) begin
          exp_rdata = ram_model[idx];
        end
      end
      dev_gpio: begin
        off = addr - GpioStart;
        case (off[RegOffWidth-1:0])
          gpio_out: begin
            for (int i = 0; i < GpoWidth; i++) begin
              if (we && be[i/8]) begin
                gpo_model[i] = wdata[i];
              end
            end
            if (!we) begin
              exp_rdata = DataWidth'(gpo_model);
            end
          end
          gpio_in: known = we;  // input pins, value set by the caller
          default: ;
        endcase
      end
      dev_timer: begin
        off = addr - TimerStart;
        case (off[RegOffWidth-1:0])
          tmr_cmp_lo, tmr_cmp_hi: begin
            idx = (off[RegOffWidth-1:0] == tmr_cmp_hi) ? 32 : 0;
            for (int b = 0; b < BeWidth; b++) begin
              if (we && be[b]) begin
                cmp_model[idx + 8*b +: 8] = wdata[8*b +: 8];
              end
            end
            if (!we) begin
              exp_rdata = cmp_model[idx +: 32];
            end
          end
          tmr_mtime_lo, tmr_mtime_hi: known = we;  // free-running counter
          default: ;
        endcase
      end
      default: exp_err = 1'b1;
    endcase
  endfunction

  ////////////////////////////////////////
  // one access from one host

  task automatic bus_access(
    input  string                name,
    input  host_e                h,
    input  logic [AddrWidth-1:0] addr,
    input  logic                 we,
    input  logic [BeWidth-1:0]   be,
    input  logic [DataWidth-1:0] wdata,
    output logic [DataWidth-1:0] rdata
  );
    host_e                other;
    int                   waited;
    logic                 granted;
    logic [DataWidth-1:0] exp_rdata;
    logic                 exp_err;
    logic                 known;
    other   = (h == host_core) ? host_accel : host_core;
    waited  = 0;
    granted = 1'b0;
    @(posedge clk_sys_in);
    host_req[h]   <= 1'b1;
    host_addr[h]  <= addr;
    host_we[h]    <= we;
    host_be[h]    <= be;
    host_wdata[h] <= wdata;
    while (!granted) begin
      @(negedge clk_sys_in);
      if (host_gnt[h]) begin
        granted = 1'b1;
      end else if (waited == GntTimeout) begin
        abort_run($sformatf("host %0d got no grant for %s in %0d cycles", h, name, GntTimeout));
      end else begin
        waited++;
      end
    end
    model_apply(addr, we, be, wdata, exp_rdata, exp_err, known);
    last_model = h;
    @(posedge clk_sys_in);
    host_req[h] <= 1'b0;
    @(negedge clk_sys_in);  // response cycle
    confirm(name, host_rvalid[h], "no response valid on the granted host");
    confirm(name, !host_rvalid[other], "response valid on the host that was not granted");
    compare_word({name, " err"}, exp_err, host_err[h]);
    if (known) begin
      compare_word({name, " rdata"}, exp_rdata, host_rdata[h]);
    end
    rdata = host_rdata[h];
  endtask

`endif

// ==== verification/tb_periph_system.sv ====
`timescale 1ns/1ps

module tb_periph_system import bus_pkg::*, soc_map_pkg::*; ();

  localparam int GpiWidth       = 8;
  localparam int GpoWidth       = 8;
  localparam int RamWords       = 16384;
  localparam int GntTimeout     = 20;   // cycles a host waits for its grant
  localparam int ArbCycles      = 8;
  localparam int PoolSize       = 8;    // RAM words used by the traffic
  localparam int RamOps         = 24;   // per host
  localparam int UnmappedOps    = 8;
  localparam int GpiPolls       = 10;
  localparam int IrqLead        = 300;
  localparam int IrqTimeout     = 1000;
  localparam int IrqDropTimeout = 5;

  logic                               clk_sys_in;
  logic                               rst_sys_in;
  logic [NumHosts-1:0]                host_req;
  logic [NumHosts-1:0][AddrWidth-1:0] host_addr;
  logic [NumHosts-1:0]                host_we;
  logic [NumHosts-1:0][BeWidth-1:0]   host_be;
  logic [NumHosts-1:0][DataWidth-1:0] host_wdata;
  logic [NumHosts-1:0]                host_gnt;
  logic [NumHosts-1:0]                host_rvalid;
  logic [NumHosts-1:0][DataWidth-1:0] host_rdata;
  logic [NumHosts-1:0]                host_err;
  logic [GpiWidth-1:0]                gp_in;
  logic [GpoWidth-1:0]                gp_o;
  logic                               timer_irq;

  integer               seed   = 32'h36c6;
  int                   checks = 0;
  int                   errors = 0;
  logic [AddrWidth-1:0] pool [PoolSize];

  periph_system #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth),
    .RamWords(RamWords)
  ) UUT (
    .clk_sys_in,
    .rst_sys_in,
    .host_req_i   (host_req),
    .host_addr_i  (host_addr),
    .host_we_i    (host_we),
    .host_be_i    (host_be),
    .host_wdata_i (host_wdata),
    .host_gnt_o   (host_gnt),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .host_err_o   (host_err),
    .gp_i         (gp_in),
    .gp_o,
    .timer_irq_o  (timer_irq)
  );

  ////////////////////////////////////////
  // reporting

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic confirm(input string name, input logic cond, input string what);
    checks++;
    if (cond !== 1'b1) begin
      $display("ERROR %s: %s", name, what);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR %s", what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("test %s done, %0d errors", name, errors - errs_before);
  endtask

  `include "periph_model.svh"

  // random reads and byte-lane writes on the RAM pool
  task automatic ram_traffic(input host_e h);
    logic [31:0]          rnd;
    logic [DataWidth-1:0] rdata;
    int                   pick;
    repeat (RamOps) begin
      rnd  = $random(seed);
      pick = {$random(seed)} % PoolSize;
      bus_access("ram", h, pool[pick], rnd[0], rnd[7:4], $random(seed), rdata);
    end
  endtask

  initial begin
    clk_sys_in = 1'b0;
    forever #10 clk_sys_in = ~clk_sys_in;
  end

  initial begin
    logic [DataWidth-1:0] rdata;
    logic [DataWidth-1:0] rsp_exp;
    logic [DataWidth-1:0] t0;
    logic [DataWidth-1:0] t1;
    logic [DataWidth-1:0] target;
    logic [AddrWidth-1:0] addr;
    logic [31:0]          rnd;
    logic [GpiWidth-1:0]  gp_val;
    logic                 rsp_err;
    logic                 known;
    logic                 rsp_pending;
    logic                 seen;
    host_e                winner;
    host_e                rsp_host;
    int                   errs_before;
    int                   waited;
    int                   tries;

    rst_sys_in = 1'b0;
    host_req   = '0;
    host_addr  = '0;
    host_we    = '0;
    host_be    = '0;
    host_wdata = '0;
    gp_in      = '0;
    repeat (4) @(posedge clk_sys_in);
    rst_sys_in <= 1'b1;

    ////////////////////////////////////////
    // arbitration, both hosts tie every cycle
    errs_before = errors;
    rsp_pending = 1'b0;
    rsp_host    = host_core;
    rsp_exp     = '0;
    rsp_err     = 1'b0;
    @(posedge clk_sys_in);
    host_req              <= '1;
    host_addr[host_core]  <= GpioStart + gpio_out;    // reads 0
    host_addr[host_accel] <= TimerStart + tmr_cmp_lo; // reads all ones
    host_we               <= '0;
    host_be               <= '1;
    for (int k = 0; k < ArbCycles; k++) begin
      @(negedge clk_sys_in);
      winner = expected_winner(host_req);
      compare_word("arb grant", 32'd1 << winner, host_gnt);
      if (rsp_pending) begin
        compare_word("arb rvalid", 32'd1 << rsp_host, host_rvalid);
        compare_word("arb rdata", rsp_exp, host_rdata[rsp_host]);
        compare_word("arb err", rsp_err, host_err[rsp_host]);
      end else begin
        compare_word("arb rvalid", 32'd0, host_rvalid);
      end
      model_apply(host_addr[winner], 1'b0, '1, '0, rsp_exp, rsp_err, known);
      last_model  = winner;
      rsp_pending = 1'b1;
      rsp_host    = winner;
    end
    @(posedge clk_sys_in);
    host_req <= '0;
    @(negedge clk_sys_in);
    compare_word("arb rvalid", 32'd1 << rsp_host, host_rvalid);
    compare_word("arb rdata", rsp_exp, host_rdata[rsp_host]);
    finish_test("arbitration", errs_before);

    ////////////////////////////////////////
    // RAM from both hosts
    errs_before = errors;
    for (int i = 0; i < PoolSize; i++) begin
      pool[i] = RamStart + (({$random(seed)} % RamWords) << 2);
      bus_access("ram init", host_core, pool[i], 1'b1, '1, $random(seed), rdata);
    end
    fork
      ram_traffic(host_core);
      ram_traffic(host_accel);
    join
    for (int i = 0; i < PoolSize; i++) begin
      bus_access("ram readback", host_accel, pool[i], 1'b0, '1, '0, rdata);
    end
    finish_test("ram", errs_before);

    // unmapped addresses, then proof that nothing moved
    errs_before = errors;
    for (int i = 0; i < UnmappedOps; i++) begin
      addr  = $random(seed);
      tries = 0;
      while (decode_addr(addr) != dev_none && tries < 100) begin
        addr = $random(seed);
        tries++;
      end
      rnd = $random(seed);
      bus_access("unmapped", host_e'(i % 2), addr, rnd[0], rnd[7:4], $random(seed), rdata);
    end
    bus_access("unmapped ram check", host_core, pool[0], 1'b0, '1, '0, rdata);
    bus_access("unmapped gpio check", host_accel, GpioStart + gpio_out, 1'b0, '1, '0, rdata);
    bus_access("unmapped cmp lo check", host_core, TimerStart + tmr_cmp_lo, 1'b0, '1, '0, rdata);
    bus_access("unmapped cmp hi check", host_accel, TimerStart + tmr_cmp_hi, 1'b0, '1, '0, rdata);
    finish_test("unmapped", errs_before);

    ////////////////////////////////////////
    // GPIO
    errs_before = errors;
    bus_access("gpio write", host_accel, GpioStart + gpio_out, 1'b1, '1, $random(seed), rdata);
    compare_word("gpio gp_o", gpo_model, gp_o);
    bus_access("gpio masked write", host_core, GpioStart + gpio_out, 1'b1, 4'b1110,
               $random(seed), rdata);
    compare_word("gpio gp_o masked", gpo_model, gp_o);
    bus_access("gpio readback", host_core, GpioStart + gpio_out, 1'b0, '1, '0, rdata);
    rnd    = $random(seed);
    gp_val = (rnd[GpiWidth-1:0] == '0) ? GpiWidth'(8'h5a) : rnd[GpiWidth-1:0];
    @(posedge clk_sys_in);
    gp_in <= gp_val;
    seen  = 1'b0;
    tries = 0;
    while (!seen && tries < GpiPolls) begin  // two-flop sync before gpio_in
      bus_access("gpio input", host_core, GpioStart + gpio_in, 1'b0, '1, '0, rdata);
      seen = (rdata === DataWidth'(gp_val));
      tries++;
    end
    confirm("gpio input", seen, "gp_i value never showed up in gpio_in");
    finish_test("gpio", errs_before);

    ////////////////////////////////////////
    // timer
    errs_before = errors;
    confirm("timer irq idle", !timer_irq, "timer interrupt high with mtimecmp at all ones");
    bus_access("timer mtime", host_core, TimerStart + tmr_mtime_lo, 1'b0, '1, '0, t0);
    bus_access("timer mtime", host_accel, TimerStart + tmr_mtime_lo, 1'b0, '1, '0, t1);
    confirm("timer mtime", t1 > t0, "second mtime_lo read is not larger than the first");
    target = t1 + IrqLead;
    bus_access("timer cmp lo", host_core, TimerStart + tmr_cmp_lo, 1'b1, '1, target, rdata);
    bus_access("timer cmp hi", host_core, TimerStart + tmr_cmp_hi, 1'b1, '1, '0, rdata);
    confirm("timer irq early", !timer_irq, "timer interrupt high before mtime reached mtimecmp");
    waited = 0;
    while (!timer_irq && waited < IrqTimeout) begin
      @(negedge clk_sys_in);
      waited++;
    end
    confirm("timer irq rise", timer_irq, "timer interrupt did not rise after mtimecmp was set");
    bus_access("timer mtime at irq", host_accel, TimerStart + tmr_mtime_lo, 1'b0, '1, '0, t0);
    confirm("timer mtime at irq", t0 >= target, "timer interrupt rose before mtimecmp");
    bus_access("timer cmp hi off", host_accel, TimerStart + tmr_cmp_hi, 1'b1, '1, '1, rdata);
    bus_access("timer cmp lo off", host_accel, TimerStart + tmr_cmp_lo, 1'b1, '1, '1, rdata);
    waited = 0;
    while (timer_irq && waited < IrqDropTimeout) begin
      @(negedge clk_sys_in);
      waited++;
    end
    confirm("timer irq drop", !timer_irq, "timer interrupt stayed high after mtimecmp reset");
    bus_access("timer cmp lo read", host_core, TimerStart + tmr_cmp_lo, 1'b0, '1, '0, rdata);
    bus_access("timer cmp hi read", host_core, TimerStart + tmr_cmp_hi, 1'b0, '1, '0, rdata);
    finish_test("timer", errs_before);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
